// File: adamnet_consts.svh
`ifndef ADAMNET_CONSTS_SVH
`define ADAMNET_CONSTS_SVH

// Table base after reset
`define PCB_BASE_INIT   16'hFEC0

// PCB field offsets
`define PCB_CMD_STAT    5'd0
`define PCB_BA_LO       5'd1
`define PCB_BA_HI       5'd2
`define PCB_MAX_DCB     5'd3

// DCB field offsets
`define DCB_CMD_STAT    5'd0
`define DCB_DEV_NUM     5'd9
`define DCB_ADD_CODE    5'd16
`define DCB_MAXL_LO     5'd17   // Max message length, low byte
`define DCB_MAXL_HI     5'd18
`define DCB_DEV_TYPE    5'd19   // 0 char device, 1 block device

// Table geometry, sized for address arithmetic
`define PCB_SIZE        16'd4
`define DCB_SIZE        16'd21
`define NUM_DCB         4'd15   // DCBs 0 to 14 follow the PCB

// PCB commands
`define CMD_PCB_SYNC1   8'h01   // Sync Z80
`define CMD_PCB_SYNC2   8'h02   // Sync master 6801
`define CMD_PCB_SNA     8'h03   // Relocate table

// DCB commands
`define CMD_STATUS      8'h01
`define CMD_SOFT_RESET  8'h02
`define CMD_WRITE       8'h03

// Responses
`define RSP_STATUS      8'h80
`define RSP_ACK         8'h90

// Device numbers
`define KBD_DEV         8'h01   // DEV_NUM nibble, ADD_CODE nibble

// Command byte seen when the Z80 reads instead of writes
`define RSP_STATUS_RD   8'hFF

`endif

// File: adamnet_pkg.sv
`default_nettype none

package adamnet_pkg;

  typedef logic [15:0] addr_t;  // Z80 / RAM address
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  dev_t;   // DCB index

  // Single-byte RAM operations
  typedef enum logic [1:0] {
    MEM_SET_PCB,  // Write at base + offset
    MEM_SET_DCB,  // Write inside a DCB
    MEM_GET_DCB   // Read inside a DCB
  } mem_kind_t;

  // Sequencer states
  typedef enum logic [3:0] {
    ST_TBL_PCB,   // Table write, PCB bytes
    ST_TBL_DCB,   // Table write, DCB loop
    ST_MEM_WAIT,  // Waiting on RAM port
    ST_IDLE,
    ST_PCB_ACK,   // Status reply at PCB offset 0
    ST_GET_CODE,  // Fetch ADD_CODE
    ST_DISPATCH,  // Device decode
    ST_REPORT     // Keyboard status report
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: adamnet_pcb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module adamnet_pcb_regs (
  input  logic               clk_i,
  input  logic               adam_reset_pcb_n_i,
  input  logic               reg_wr,        // Z80 write to a PCB register
  input  logic [1:0]         reg_offset,
  input  adamnet_pkg::byte_t reg_data,
  input  logic               relocate,      // Commit pending base
  output adamnet_pkg::addr_t pcb_base,      // Active table base
  output adamnet_pkg::addr_t pending_base,  // Base staged by BA_LO / BA_HI
  output adamnet_pkg::dev_t  max_dcb
);

`include "adamnet_consts.svh"

  always_ff @(posedge clk_i) begin
    if (!adam_reset_pcb_n_i) begin
      pcb_base     <= `PCB_BASE_INIT;
      pending_base <= `PCB_BASE_INIT;
      max_dcb      <= `NUM_DCB;       // All DCBs live
    end else begin
      if (reg_wr) begin
        case ({3'b000, reg_offset})
          `PCB_BA_LO:   pending_base[7:0]  <= reg_data;
          `PCB_BA_HI:   pending_base[15:8] <= reg_data;
          `PCB_MAX_DCB: max_dcb            <= reg_data[3:0];  // Count fits a nibble
          default: ;  // CMD_STAT handled by sequencer
        endcase
      end
      // Only on SNA, never together with reg_wr
      if (relocate) begin
        pcb_base <= pending_base;
      end
    end
  end

endmodule

`default_nettype wire

// File: adamnet_bus_snoop.sv
`timescale 1ns/100ps
`default_nettype none

module adamnet_bus_snoop (
  input  logic               clk_i,
  input  logic               adam_reset_pcb_n_i,
  input  logic               z80_wr,
  input  logic               z80_rd,
  input  adamnet_pkg::addr_t z80_addr,
  input  adamnet_pkg::byte_t z80_data_wr,
  input  adamnet_pkg::addr_t pcb_base,
  input  adamnet_pkg::dev_t  max_dcb,
  input  logic               busy,
  output logic               pcb_hit,     // Z80 write inside PCB
  output logic               dcb_hit,     // Z80 access to a DCB command byte
  output logic [1:0]         hit_offset,
  output adamnet_pkg::dev_t  hit_dev,
  output adamnet_pkg::byte_t hit_data
);

`include "adamnet_consts.svh"

  import adamnet_pkg::*;

  addr_t last_addr;  // Last sampled access
  logic  last_wr;
  addr_t offset;     // Distance from table base, wraps
  logic  sample;
  logic  is_new;
  logic  in_pcb;
  logic  cmd_hit;
  dev_t  cmd_dev;

  // Hold off while sequencer busy or a strobe is still being taken
  assign sample = ~busy & ~pcb_hit & ~dcb_hit;
  assign is_new = (z80_addr != last_addr) || (z80_wr != last_wr);
  assign offset = z80_addr - pcb_base;
  assign in_pcb = (offset < `PCB_SIZE);  // Offset 0 included for SYNC

  // Command byte of DCB 1 up to max_dcb
  always_comb begin
    cmd_hit = 1'b0;
    cmd_dev = '0;
    for (int i = 1; i < int'(`NUM_DCB); i++) begin
      if (dev_t'(i) <= max_dcb && offset == `PCB_SIZE + 16'(i) * `DCB_SIZE) begin
        cmd_hit = 1'b1;
        cmd_dev = dev_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pcb_hit <= 1'b0;  // One-cycle strobes
    dcb_hit <= 1'b0;
    if (!adam_reset_pcb_n_i) begin
      last_addr <= '1;
      last_wr   <= 1'b0;
    end else if (sample && is_new) begin
      last_addr <= z80_addr;
      last_wr   <= z80_wr;
      pcb_hit   <= in_pcb & z80_wr;
      dcb_hit   <= cmd_hit & (z80_wr | z80_rd);
    end
  end

  // Payload beside the strobes
  always_ff @(posedge clk_i) begin
    if (sample && is_new) begin
      hit_offset <= offset[1:0];
      hit_dev    <= cmd_dev;
      hit_data   <= z80_wr ? z80_data_wr : `RSP_STATUS_RD;
    end
  end

endmodule

`default_nettype wire

// File: adamnet_ram_port.sv
`timescale 1ns/100ps
`default_nettype none

module adamnet_ram_port (
  input  logic                   clk_i,
  input  logic                   adam_reset_pcb_n_i,
  input  adamnet_pkg::addr_t     pcb_base,
  input  logic                   mem_req,     // One request at a time
  input  adamnet_pkg::mem_kind_t mem_kind,
  input  adamnet_pkg::dev_t      mem_dev,
  input  logic [4:0]             mem_offset,
  input  adamnet_pkg::byte_t     mem_wdata,
  output logic                   mem_done,    // Cycle after the RAM ack
  output adamnet_pkg::byte_t     mem_rdata,
  output adamnet_pkg::addr_t     ramb_addr,
  output logic                   ramb_wr,
  output logic                   ramb_rd,
  output adamnet_pkg::byte_t     ramb_dout,
  input  adamnet_pkg::byte_t     ramb_din,
  input  logic                   ramb_wr_ack,
  input  logic                   ramb_rd_ack
);

`include "adamnet_consts.svh"

  import adamnet_pkg::*;

  addr_t dcb_start;  // First byte of the addressed DCB
  addr_t req_addr;
  logic  ack;

  assign ack = (ramb_wr & ramb_wr_ack) | (ramb_rd & ramb_rd_ack);

  always_comb begin
    dcb_start = pcb_base + `PCB_SIZE + {12'h000, mem_dev} * `DCB_SIZE;
    if (mem_kind == MEM_SET_PCB) begin
      req_addr = pcb_base + {11'h000, mem_offset};
    end else begin
      req_addr = dcb_start + {11'h000, mem_offset};
    end
  end

  // Strobe held until ack, no timeout
  always_ff @(posedge clk_i) begin
    mem_done <= 1'b0;
    if (!adam_reset_pcb_n_i) begin
      ramb_wr <= 1'b0;
      ramb_rd <= 1'b0;
    end else if (mem_req) begin
      ramb_wr <= (mem_kind != MEM_GET_DCB);
      ramb_rd <= (mem_kind == MEM_GET_DCB);
    end else if (ack) begin
      ramb_wr  <= 1'b0;
      ramb_rd  <= 1'b0;
      mem_done <= 1'b1;
    end
  end

  // Address and data frozen for the whole access
  always_ff @(posedge clk_i) begin
    if (mem_req) begin
      ramb_addr <= req_addr;
      ramb_dout <= mem_wdata;
    end
    if (ramb_rd && ramb_rd_ack) begin
      mem_rdata <= ramb_din;  // Valid with mem_done
    end
  end

endmodule

`default_nettype wire

// File: adamnet_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module adamnet_ctrl (
  input  logic                   clk_i,
  input  logic                   adam_reset_pcb_n_i,
  input  logic                   pcb_hit,
  input  logic                   dcb_hit,
  input  logic [1:0]             hit_offset,
  input  adamnet_pkg::dev_t      hit_dev,
  input  adamnet_pkg::byte_t     hit_data,
  input  adamnet_pkg::addr_t     pending_base,
  output logic                   reg_wr,
  output logic [1:0]             reg_offset,
  output adamnet_pkg::byte_t     reg_data,
  output logic                   relocate,
  output logic                   mem_req,
  output adamnet_pkg::mem_kind_t mem_kind,
  output adamnet_pkg::dev_t      mem_dev,
  output logic [4:0]             mem_offset,
  output adamnet_pkg::byte_t     mem_wdata,
  input  logic                   mem_done,
  input  adamnet_pkg::byte_t     mem_rdata,
  output logic                   busy,
  output logic                   adamnet_wait_n
);

`include "adamnet_consts.svh"

  import adamnet_pkg::*;

  ctrl_state_t state;
  ctrl_state_t ret_state;  // Where to go after mem_done
  logic [1:0]  step;       // PCB bytes, DCB halves, report fields
  logic        sna_run;    // Table write belongs to a relocation
  dev_t        dev;        // Loop index or addressed DCB
  logic [3:0]  dev_hi;     // From DEV_NUM
  byte_t       cmd;        // Command byte from snoop
  byte_t       rd_byte;    // Last DCB byte read
  byte_t       dev_id;

  assign dev_id         = {dev_hi, rd_byte[3:0]};
  assign busy           = (state != ST_IDLE);
  assign adamnet_wait_n = ~busy;

  // Issue one RAM request and park until done
  task automatic send(input mem_kind_t kind, input dev_t d, input logic [4:0] offs,
                      input byte_t data, input ctrl_state_t nxt);
    mem_req    <= 1'b1;
    mem_kind   <= kind;
    mem_dev    <= d;
    mem_offset <= offs;
    mem_wdata  <= data;
    ret_state  <= nxt;
    state      <= ST_MEM_WAIT;
  endtask

  always_ff @(posedge clk_i) begin
    mem_req  <= 1'b0;
    reg_wr   <= 1'b0;
    relocate <= 1'b0;
    if (!adam_reset_pcb_n_i) begin
      state     <= ST_TBL_PCB;  // Build table straight out of reset
      ret_state <= ST_IDLE;
      step      <= 2'd0;
      sna_run   <= 1'b0;
      dev       <= '0;
    end else begin
      case (state)
        // Pending equals active base here
        ST_TBL_PCB: begin
          step <= step + 2'd1;
          case (step)
            2'd0: send(MEM_SET_PCB, dev, `PCB_BA_LO, pending_base[7:0], ST_TBL_PCB);
            2'd1: send(MEM_SET_PCB, dev, `PCB_BA_HI, pending_base[15:8], ST_TBL_PCB);
            default: begin
              step <= 2'd0;
              dev  <= '0;
              send(MEM_SET_PCB, dev, `PCB_MAX_DCB, {4'h0, `NUM_DCB}, ST_TBL_DCB);
            end
          endcase
        end
        ST_TBL_DCB: begin
          step[0] <= ~step[0];
          if (!step[0]) begin
            send(MEM_SET_DCB, dev, `DCB_DEV_NUM, 8'h00, ST_TBL_DCB);
          end else begin
            dev <= dev + 4'd1;
            send(MEM_SET_DCB, dev, `DCB_ADD_CODE, {4'h0, dev},
                 (dev != `NUM_DCB - 4'd1) ? ST_TBL_DCB :
                 sna_run ? ST_PCB_ACK : ST_IDLE);
          end
        end
        ST_MEM_WAIT: begin
          if (mem_done) begin
            rd_byte <= mem_rdata;  // Only meaningful after a get
            state   <= ret_state;
          end
        end
        ST_IDLE: begin
          if (pcb_hit) begin
            cmd        <= hit_data;
            reg_offset <= hit_offset;
            reg_data   <= hit_data;
            if ({3'b000, hit_offset} == `PCB_CMD_STAT) begin
              case (hit_data)
                `CMD_PCB_SYNC1, `CMD_PCB_SYNC2: state <= ST_PCB_ACK;
                `CMD_PCB_SNA: begin
                  relocate <= 1'b1;  // Active base valid next cycle
                  sna_run  <= 1'b1;
                  step     <= 2'd0;
                  state    <= ST_TBL_PCB;
                end
                default: ;  // Unknown PCB command ignored
              endcase
            end else begin
              reg_wr <= 1'b1;  // BA_LO, BA_HI or MAX_DCB
            end
          end else if (dcb_hit) begin
            dev <= hit_dev;
            cmd <= hit_data;
            send(MEM_GET_DCB, hit_dev, `DCB_DEV_NUM, 8'h00, ST_GET_CODE);
          end
        end
        ST_PCB_ACK: begin
          sna_run <= 1'b0;
          send(MEM_SET_PCB, dev, `PCB_CMD_STAT, `RSP_STATUS | cmd, ST_IDLE);
        end
        ST_GET_CODE: begin
          dev_hi <= rd_byte[3:0];
          send(MEM_GET_DCB, dev, `DCB_ADD_CODE, 8'h00, ST_DISPATCH);
        end
        ST_DISPATCH: begin
          if (dev_id == `KBD_DEV) begin
            case (cmd)
              `CMD_STATUS, `CMD_SOFT_RESET: begin
                step  <= 2'd0;
                state <= ST_REPORT;
              end
              `CMD_WRITE: send(MEM_SET_DCB, dev, `DCB_CMD_STAT, `RSP_ACK + 8'h0B, ST_IDLE);
              `RSP_STATUS_RD: send(MEM_SET_DCB, dev, `DCB_CMD_STAT, `RSP_STATUS, ST_IDLE);
              default: state <= ST_IDLE;
            endcase
          end else begin
            send(MEM_SET_DCB, dev, `DCB_CMD_STAT, 8'h00, ST_IDLE);  // No such device
          end
        end
        // Char device, one byte buffer
        ST_REPORT: begin
          step <= step + 2'd1;
          case (step)
            2'd0: send(MEM_SET_DCB, dev, `DCB_CMD_STAT, `RSP_STATUS, ST_REPORT);
            2'd1: send(MEM_SET_DCB, dev, `DCB_MAXL_LO, 8'h01, ST_REPORT);
            2'd2: send(MEM_SET_DCB, dev, `DCB_MAXL_HI, 8'h00, ST_REPORT);
            default: send(MEM_SET_DCB, dev, `DCB_DEV_TYPE, 8'h00, ST_IDLE);
          endcase
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: adamnet_top.sv
`timescale 1ns/100ps
`default_nettype none

module adamnet_top (
  input  logic               clk_i,
  input  logic               adam_reset_pcb_n_i,
  input  logic               z80_wr,
  input  logic               z80_rd,
  input  adamnet_pkg::addr_t z80_addr,
  input  adamnet_pkg::byte_t z80_data_wr,
  output adamnet_pkg::addr_t ramb_addr,
  output logic               ramb_wr,
  output logic               ramb_rd,
  output adamnet_pkg::byte_t ramb_dout,
  input  adamnet_pkg::byte_t ramb_din,
  input  logic               ramb_wr_ack,
  input  logic               ramb_rd_ack,
  output logic               adamnet_wait_n   // Low while the engine works
);

  import adamnet_pkg::*;

  addr_t     pcb_base;      // Active table base
  addr_t     pending_base;
  dev_t      max_dcb;
  logic      busy;
  logic      pcb_hit;
  logic      dcb_hit;
  logic [1:0] hit_offset;
  dev_t      hit_dev;
  byte_t     hit_data;
  logic      reg_wr;
  logic [1:0] reg_offset;
  byte_t     reg_data;
  logic      relocate;
  logic      mem_req;       // ctrl to RAM port
  mem_kind_t mem_kind;
  dev_t      mem_dev;
  logic [4:0] mem_offset;
  byte_t     mem_wdata;
  logic      mem_done;
  byte_t     mem_rdata;

  adamnet_pcb_regs u_regs (
    .clk_i, .adam_reset_pcb_n_i, .reg_wr, .reg_offset, .reg_data, .relocate,
    .pcb_base, .pending_base, .max_dcb
  );

  adamnet_bus_snoop u_snoop (
    .clk_i, .adam_reset_pcb_n_i, .z80_wr, .z80_rd, .z80_addr, .z80_data_wr,
    .pcb_base, .max_dcb, .busy, .pcb_hit, .dcb_hit, .hit_offset, .hit_dev, .hit_data
  );

  adamnet_ram_port u_ram (
    .clk_i, .adam_reset_pcb_n_i, .pcb_base, .mem_req, .mem_kind, .mem_dev, .mem_offset,
    .mem_wdata, .mem_done, .mem_rdata, .ramb_addr, .ramb_wr, .ramb_rd, .ramb_dout,
    .ramb_din, .ramb_wr_ack, .ramb_rd_ack
  );

  adamnet_ctrl u_ctrl (
    .clk_i, .adam_reset_pcb_n_i, .pcb_hit, .dcb_hit, .hit_offset, .hit_dev, .hit_data,
    .pending_base, .reg_wr, .reg_offset, .reg_data, .relocate, .mem_req, .mem_kind,
    .mem_dev, .mem_offset, .mem_wdata, .mem_done, .mem_rdata, .busy, .adamnet_wait_n
  );

endmodule

`default_nettype wire

// File: adamnet_properties.sv
`timescale 1ns/100ps
`default_nettype none

module adamnet_properties (
  input logic               clk_i,
  input logic               adam_reset_pcb_n_i,
  input adamnet_pkg::addr_t ramb_addr,
  input logic               ramb_wr,
  input logic               ramb_rd,
  input adamnet_pkg::byte_t ramb_dout,
  input logic               ramb_wr_ack,
  input logic               ramb_rd_ack,
  input logic               adamnet_wait_n
);

  int unsigned violations = 0;

  // One direction at a time
  no_wr_rd_overlap: assert property (@(posedge clk_i) disable iff (!adam_reset_pcb_n_i)
    !(ramb_wr && ramb_rd))
  else begin
    violations++;
    $error("ramb_wr and ramb_rd high together");
  end

  // RAM traffic only while the engine is busy
  strobe_while_busy: assert property (@(posedge clk_i) disable iff (!adam_reset_pcb_n_i)
    (ramb_wr || ramb_rd) |-> !adamnet_wait_n)
  else begin
    violations++;
    $error("RAM strobe with adamnet_wait_n high");
  end

  // Access held steady until acked
  stable_until_ack: assert property (@(posedge clk_i) disable iff (!adam_reset_pcb_n_i)
    (ramb_wr || ramb_rd) && !(ramb_wr_ack || ramb_rd_ack) |=>
    $stable(ramb_addr) && $stable(ramb_dout) && $stable(ramb_wr) && $stable(ramb_rd))
  else begin
    violations++;
    $error("RAM access changed before its ack");
  end

endmodule

`default_nettype wire

// File: tb_adamnet.sv
`timescale 1ns/100ps
`default_nettype none

module tb_adamnet;

`include "adamnet_consts.svh"

  import adamnet_pkg::*;

  // Table write takes near 250 cycles at worst-case acks and each test well under 1000
  localparam int TIMEOUT_CYCLES = 20000;

  logic  clk_i;
  logic  adam_reset_pcb_n_i;
  logic  z80_wr;
  logic  z80_rd;
  addr_t z80_addr;
  byte_t z80_data_wr;
  addr_t ramb_addr;
  logic  ramb_wr;
  logic  ramb_rd;
  byte_t ramb_dout;
  byte_t ramb_din;
  logic  ramb_wr_ack;
  logic  ramb_rd_ack;
  logic  adamnet_wait_n;

  byte_t       ram [0:65535];  // Shared system RAM
  logic [31:0] rng_state;
  int          ack_delay = 0;  // Cycles left before the RAM ack
  int          cycles = 0;

  adamnet_top UUT (.*);

  bind adamnet_top adamnet_properties props (
    .clk_i(clk_i), .adam_reset_pcb_n_i(adam_reset_pcb_n_i), .ramb_addr(ramb_addr),
    .ramb_wr(ramb_wr), .ramb_rd(ramb_rd), .ramb_dout(ramb_dout), .ramb_wr_ack(ramb_wr_ack),
    .ramb_rd_ack(ramb_rd_ack), .adamnet_wait_n(adamnet_wait_n)
  );

  always #50 clk_i = ~clk_i;  // 100 ns period

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  always @(negedge clk_i) begin
    if (UUT.props.violations != 0) begin
      $display("A RAM bus property of the DUT was violated");
      $display("Testbench failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // RAM model with ack after 1 to 4 cycles
  always @(negedge clk_i) begin
    ramb_wr_ack = 1'b0;
    ramb_rd_ack = 1'b0;
    if (adam_reset_pcb_n_i && (ramb_wr || ramb_rd)) begin
      if (ack_delay == 0) begin
        rng_state = xorshift32(rng_state);  // New access
        ack_delay = 1 + int'(rng_state[1:0]);
      end
      ack_delay = ack_delay - 1;
      if (ack_delay == 0 && ramb_wr) begin
        ram[ramb_addr] = ramb_dout;
        ramb_wr_ack    = 1'b1;
      end else if (ack_delay == 0) begin
        ramb_din    = ram[ramb_addr];
        ramb_rd_ack = 1'b1;
      end
    end
  end

  // DCB byte address in a table at base
  function automatic addr_t dcb_addr(input addr_t base, input int j, input logic [4:0] offs);
    return base + `PCB_SIZE + 16'(j) * `DCB_SIZE + {11'h000, offs};
  endfunction

  task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0d ns: %s = %02h, expected %02h", $time, name, actual,
               expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (!adamnet_wait_n) @(negedge clk_i);
  endtask

  // Z80 access held two cycles so the snoop registers it and the sequencer takes the strobe
  task automatic bus_access(input addr_t addr, input byte_t data, input logic wr,
                            input logic rd);
    @(negedge clk_i);
    z80_addr    = addr;
    z80_data_wr = data;
    z80_wr      = wr;
    z80_rd      = rd;
    if (wr) ram[addr] = data;  // Z80 write lands in RAM too
    repeat (2) @(negedge clk_i);
    z80_addr = 16'h0000;       // Neutral address outside the table
    z80_wr   = 1'b0;
    z80_rd   = 1'b0;
    wait_idle();
  endtask

  task automatic check_table(input addr_t base);
    addr_t a;
    check_byte($sformatf("ram[%04h]", base + 16'd1), ram[base + 16'd1], base[7:0]);
    check_byte($sformatf("ram[%04h]", base + 16'd2), ram[base + 16'd2], base[15:8]);
    check_byte($sformatf("ram[%04h]", base + 16'd3), ram[base + 16'd3], 8'h0F);
    for (int j = 0; j < 15; j++) begin
      a = dcb_addr(base, j, `DCB_DEV_NUM);
      check_byte($sformatf("ram[%04h] DEV_NUM", a), ram[a], 8'h00);
      a = dcb_addr(base, j, `DCB_ADD_CODE);
      check_byte($sformatf("ram[%04h] ADD_CODE", a), ram[a], 8'(j));
    end
  endtask

  task automatic run_sync_cmds();
    bus_access(16'hFEC0, 8'h01, 1'b1, 1'b0);
    check_byte("ram[FEC0] after SYNC1", ram[16'hFEC0], 8'h81);
    bus_access(16'hFEC0, 8'h02, 1'b1, 1'b0);
    check_byte("ram[FEC0] after SYNC2", ram[16'hFEC0], 8'h82);
  endtask

  // STATUS to DCB 1 and its report fields
  task automatic keyboard_status(input addr_t base);
    addr_t cmd_addr;
    cmd_addr = dcb_addr(base, 1, `DCB_CMD_STAT);
    bus_access(cmd_addr, 8'h01, 1'b1, 1'b0);
    check_byte("kbd CMD_STAT", ram[cmd_addr], 8'h80);
    check_byte("kbd MAXL_LO", ram[dcb_addr(base, 1, `DCB_MAXL_LO)], 8'h01);
    check_byte("kbd MAXL_HI", ram[dcb_addr(base, 1, `DCB_MAXL_HI)], 8'h00);
    check_byte("kbd DEV_TYPE", ram[dcb_addr(base, 1, `DCB_DEV_TYPE)], 8'h00);
  endtask

  task automatic keyboard_cmds();
    addr_t cmd_addr;
    cmd_addr = dcb_addr(16'hFEC0, 1, `DCB_CMD_STAT);
    keyboard_status(16'hFEC0);
    bus_access(cmd_addr, 8'h03, 1'b1, 1'b0);
    check_byte("kbd CMD_STAT after WRITE", ram[cmd_addr], 8'h9B);
    bus_access(cmd_addr, 8'h00, 1'b0, 1'b1);  // Status read
    check_byte("kbd CMD_STAT after read", ram[cmd_addr], 8'h80);
  endtask

  task automatic other_device_cmd();
    addr_t cmd_addr;
    cmd_addr = dcb_addr(16'hFEC0, 3, `DCB_CMD_STAT);
    ram[dcb_addr(16'hFEC0, 3, `DCB_DEV_NUM)] = 8'h08;  // Not the keyboard
    bus_access(cmd_addr, 8'h01, 1'b1, 1'b0);
    check_byte("DCB 3 CMD_STAT", ram[cmd_addr], 8'h00);
  endtask

  task automatic relocate_table();
    bus_access(16'hFEC1, 8'h00, 1'b1, 1'b0);  // Pending base 4000h
    bus_access(16'hFEC2, 8'h40, 1'b1, 1'b0);
    bus_access(16'hFEC0, 8'h03, 1'b1, 1'b0);  // SNA
    check_table(16'h4000);
    check_byte("ram[4000] after SNA", ram[16'h4000], 8'h83);
    keyboard_status(16'h4000);
  endtask

  initial begin
    rng_state          = 32'd26280;
    clk_i              = 1'b0;
    adam_reset_pcb_n_i = 1'b0;
    z80_wr             = 1'b0;
    z80_rd             = 1'b0;
    z80_addr           = 16'h0000;
    z80_data_wr        = 8'h00;
    ramb_din           = 8'h00;
    ramb_wr_ack        = 1'b0;
    ramb_rd_ack        = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      ram[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
    end
    repeat (16) @(negedge clk_i);
    check_byte("adamnet_wait_n in reset", {7'd0, adamnet_wait_n}, 8'h00);
    check_byte("ramb_wr in reset", {7'd0, ramb_wr}, 8'h00);
    check_byte("ramb_rd in reset", {7'd0, ramb_rd}, 8'h00);
    adam_reset_pcb_n_i = 1'b1;
    wait_idle();                // Table init done
    check_table(16'hFEC0);
    run_sync_cmds();
    keyboard_cmds();
    other_device_cmd();
    relocate_table();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
adamnet_pkg.sv
adamnet_pcb_regs.sv
adamnet_bus_snoop.sv
adamnet_ram_port.sv
adamnet_ctrl.sv
adamnet_top.sv
adamnet_properties.sv
tb_adamnet.sv

// File: Makefile
TOP = tb_adamnet

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module adamnet_top
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	if grep -q "Testbench failed" sim.log || [ $$status -ne 0 ]; then \
	  echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
